// File: ex_stage.f
+incdir+include
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_writeback.sv
design/ex_stage.sv
verif/ex_stage_properties.sv
verif/ex_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = ex_stage_tb
FILELIST  = ex_stage.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/ex_stage_tb.sv
// Execute stage testbench
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_stage_tb;

  import ex_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int ROUNDS         = 40;

  logic      clk;
  logic      rst_n;
  alu_op_e   alu_operator_i;
  word_t     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  logic      alu_en_i;
  mul_op_e   mult_operator_i;
  word_t     mult_operand_a_i, mult_operand_b_i, mult_operand_c_i;
  logic      mult_en_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      branch_in_ex_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_waddr_i;
  logic      regfile_we_i;
  logic      lsu_en_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i, lsu_err_i, wb_ready_i;
  reg_addr_t regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  logic      regfile_alu_we_fw_o, regfile_we_wb_o;
  word_t     regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;
  logic      branch_decision_o, mult_multicycle_o, ex_ready_o, ex_valid_o;

  integer    seed;
  int        tests;
  int        checks;
  int        errors;

  ex_stage dut0 (.*);

  // Strobe checker on the DUT
  bind ex_stage ex_stage_properties props0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_in_ex_i (branch_in_ex_i),
    .wb_ready_i     (wb_ready_i),
    .we_wb_i        (regfile_we_wb_o),
    .multicycle_i   (mult_multicycle_o),
    .ex_ready_i     (ex_ready_o),
    .ex_valid_i     (ex_valid_o)
  );

  // 40 ns period
  always #20 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // Branch condition, or less-than bit for SLT and SLTU
  function automatic logic cmp_model(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return $signed(a) < $signed(b);
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_LTU, ALU_SLTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[`EX_SHAMT_W-1:0];
      ALU_SRL: return a >> b[`EX_SHAMT_W-1:0];
      ALU_SRA: return $signed(a) >>> b[`EX_SHAMT_W-1:0];
      default: return {{(`EX_XLEN-1){1'b0}}, cmp_model(op, a, b)};
    endcase
  endfunction

  function automatic word_t mul_model(input mul_op_e op, input word_t a, input word_t b,
                                      input word_t c);
    logic [2*`EX_XLEN-1:0] ae;
    logic [2*`EX_XLEN-1:0] be;
    logic [2*`EX_XLEN-1:0] p;
    if (op == MUL_MUL) return a * b;
    if (op == MUL_MAC) return a * b + c;
    // Sign extend per operator, keep the upper word
    ae = (op == MUL_MULH || op == MUL_MULHSU) ? {{`EX_XLEN{a[`EX_XLEN-1]}}, a}
                                              : {{`EX_XLEN{1'b0}}, a};
    be = (op == MUL_MULH) ? {{`EX_XLEN{b[`EX_XLEN-1]}}, b} : {{`EX_XLEN{1'b0}}, b};
    p  = ae * be;
    return p[2*`EX_XLEN-1:`EX_XLEN];
  endfunction

  //////////////////////////////
  // Compare and report
  //////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int base);
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - base);
  endtask

  // Count falling edges until the stage accepts
  task automatic wait_ex_ready(output int cycles);
    cycles = 0;
    while (ex_ready_o !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (ex_ready_o !== 1'b1) begin
      errors++;
      $display("Timeout after %0d cycles waiting for ex_ready_o to rise", cycles);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic init_inputs();
    clk = 1'b0;
    rst_n = 1'b0;
    alu_operator_i = ALU_ADD;
    alu_operand_a_i = '0;
    alu_operand_b_i = '0;
    alu_operand_c_i = '0;
    alu_en_i = 1'b0;
    mult_operator_i = MUL_MUL;
    mult_operand_a_i = '0;
    mult_operand_b_i = '0;
    mult_operand_c_i = '0;
    mult_en_i = 1'b0;
    csr_access_i = 1'b0;
    csr_rdata_i = '0;
    branch_in_ex_i = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_alu_we_i = 1'b0;
    regfile_waddr_i = '0;
    regfile_we_i = 1'b0;
    lsu_en_i = 1'b0;
    lsu_rdata_i = '0;
    lsu_ready_ex_i = 1'b1;
    lsu_err_i = 1'b0;
    wb_ready_i = 1'b1;
  endtask

  // All units off, readies up, called right after a rising edge
  task automatic set_quiet();
    alu_en_i <= 1'b0;
    mult_en_i <= 1'b0;
    csr_access_i <= 1'b0;
    lsu_en_i <= 1'b0;
    lsu_err_i <= 1'b0;
    regfile_we_i <= 1'b0;
    branch_in_ex_i <= 1'b0;
    lsu_ready_ex_i <= 1'b1;
    wb_ready_i <= 1'b1;
  endtask

  task automatic alu_test();
    alu_op_e   op;
    word_t     a, b;
    reg_addr_t waddr;
    logic      we;
    int        base;
    base = errors;
    for (int i = 0; i < ROUNDS; i++) begin
      op = alu_op_e'(4'(rnd()));
      a = rnd();
      b = rnd();
      waddr = 6'(rnd());
      we = 1'(rnd());
      @(posedge clk);
      set_quiet();
      alu_en_i <= 1'b1;
      alu_operator_i <= op;
      alu_operand_a_i <= a;
      alu_operand_b_i <= b;
      regfile_alu_waddr_i <= waddr;
      regfile_alu_we_i <= we;
      @(negedge clk);
      check_word("regfile_alu_wdata_fw_o", alu_model(op, a, b), regfile_alu_wdata_fw_o);
      check_addr("regfile_alu_waddr_fw_o", waddr, regfile_alu_waddr_fw_o);
      check_bit("regfile_alu_we_fw_o", we, regfile_alu_we_fw_o);
    end
    report_test("alu_ops", base);
  endtask

  task automatic branch_test();
    alu_op_e op;
    word_t   a, b, c;
    int      base;
    base = errors;
    for (int i = 0; i < ROUNDS; i++) begin
      op = alu_op_e'(4'(8 + rnd() % 8));
      a = rnd();
      // Equal operands now and then
      b = (rnd() % 4 == 0) ? a : rnd();
      c = rnd();
      @(posedge clk);
      set_quiet();
      alu_en_i <= 1'b1;
      alu_operator_i <= op;
      alu_operand_a_i <= a;
      alu_operand_b_i <= b;
      alu_operand_c_i <= c;
      @(negedge clk);
      check_bit("branch_decision_o", cmp_model(op, a, b), branch_decision_o);
      check_word("jump_target_o", c, jump_target_o);
    end
    report_test("branch_compare", base);
  endtask

  task automatic mult_test();
    mul_op_e op;
    word_t   a, b, c;
    int      cycles;
    int      base;
    base = errors;
    for (int i = 0; i < 2 * ROUNDS; i++) begin
      // Low products first, then high halves
      op = (i < ROUNDS) ? mul_op_e'(3'(rnd() % 2)) : mul_op_e'(3'(2 + rnd() % 3));
      a = rnd();
      b = rnd();
      c = rnd();
      @(posedge clk);
      set_quiet();
      mult_en_i <= 1'b1;
      mult_operator_i <= op;
      mult_operand_a_i <= a;
      mult_operand_b_i <= b;
      mult_operand_c_i <= c;
      @(negedge clk);
      if (i >= ROUNDS) begin
        check_bit("mult_multicycle_o", 1'b1, mult_multicycle_o);
        check_bit("ex_ready_o", 1'b0, ex_ready_o);
        wait_ex_ready(cycles);
        checks++;
        if (cycles != 1) begin
          errors++;
          $display("High-half product took %0d extra cycles instead of one", cycles);
        end
      end
      check_bit("ex_ready_o", 1'b1, ex_ready_o);
      check_bit("mult_multicycle_o", 1'b0, mult_multicycle_o);
      check_word("regfile_alu_wdata_fw_o", mul_model(op, a, b, c), regfile_alu_wdata_fw_o);
    end
    report_test("multiplier", base);
  endtask

  task automatic priority_test();
    alu_op_e aop;
    mul_op_e mop;
    word_t   a, b, c, csr, exp;
    logic    csr_en, mul_en, alu_en;
    int      base;
    base = errors;
    for (int i = 0; i < ROUNDS; i++) begin
      aop = alu_op_e'(4'(rnd()));
      mop = mul_op_e'(3'(rnd() % 2));
      a = rnd();
      b = rnd();
      c = rnd();
      csr = rnd();
      csr_en = 1'(rnd());
      mul_en = 1'(rnd());
      alu_en = 1'(rnd());
      @(posedge clk);
      set_quiet();
      csr_access_i <= csr_en;
      csr_rdata_i <= csr;
      mult_en_i <= mul_en;
      alu_en_i <= alu_en;
      alu_operator_i <= aop;
      mult_operator_i <= mop;
      alu_operand_a_i <= a;
      alu_operand_b_i <= b;
      mult_operand_a_i <= a;
      mult_operand_b_i <= b;
      mult_operand_c_i <= c;
      // CSR over multiplier over ALU
      if (csr_en) exp = csr;
      else if (mul_en) exp = mul_model(mop, a, b, c);
      else if (alu_en) exp = alu_model(aop, a, b);
      else exp = '0;
      @(negedge clk);
      check_word("regfile_alu_wdata_fw_o", exp, regfile_alu_wdata_fw_o);
    end
    report_test("forward_priority", base);
  endtask

  task automatic lsu_write_test();
    reg_addr_t addr, exp_addr;
    logic      we, err;
    word_t     data;
    int        base;
    base = errors;
    // No write has been kept since reset
    exp_addr = `EX_RADDR_RST;
    for (int i = 0; i < ROUNDS; i++) begin
      we = 1'(rnd());
      err = 1'(rnd());
      addr = 6'(rnd());
      data = rnd();
      @(posedge clk);
      set_quiet();
      lsu_en_i <= 1'b1;
      regfile_we_i <= we;
      lsu_err_i <= err;
      regfile_waddr_i <= addr;
      lsu_rdata_i <= data;
      @(negedge clk);
      check_bit("ex_valid_o", 1'b1, ex_valid_o);
      // Idle cycle before flushed the enable
      check_bit("regfile_we_wb_o", 1'b0, regfile_we_wb_o);
      if (we && !err) exp_addr = addr;
      data = rnd();
      @(posedge clk);
      set_quiet();
      lsu_rdata_i <= data;
      @(negedge clk);
      check_bit("regfile_we_wb_o", we & ~err, regfile_we_wb_o);
      check_addr("regfile_waddr_wb_o", exp_addr, regfile_waddr_wb_o);
      check_word("regfile_wdata_wb_o", data, regfile_wdata_wb_o);
    end
    report_test("lsu_writeback", base);
  endtask

  task automatic backpressure_test();
    logic wb, lsu, br, any_en;
    logic alu_en, lsu_en, csr_en;
    int   base;
    base = errors;
    for (int i = 0; i < ROUNDS; i++) begin
      wb = 1'(rnd());
      lsu = 1'(rnd());
      br = 1'(rnd());
      alu_en = 1'(rnd());
      lsu_en = 1'(rnd());
      csr_en = 1'(rnd());
      any_en = alu_en | lsu_en | csr_en;
      @(posedge clk);
      set_quiet();
      wb_ready_i <= wb;
      lsu_ready_ex_i <= lsu;
      branch_in_ex_i <= br;
      alu_en_i <= alu_en;
      lsu_en_i <= lsu_en;
      csr_access_i <= csr_en;
      @(negedge clk);
      check_bit("ex_ready_o", (wb & lsu) | br, ex_ready_o);
      check_bit("ex_valid_o", any_en & wb & lsu, ex_valid_o);
    end
    report_test("backpressure", base);
  endtask

  initial begin
    seed = 32'h9cdf_e09f;
    tests = 0;
    checks = 0;
    errors = 0;
    init_inputs();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    alu_test();
    branch_test();
    mult_test();
    priority_test();
    lsu_write_test();
    backpressure_test();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verif/ex_stage_properties.sv
// Execute stage strobe assertions
`timescale 1ns/100ps

module ex_stage_properties (
  input logic clk,
  input logic rst_n,
  input logic branch_in_ex_i,
  input logic wb_ready_i,
  input logic we_wb_i,
  input logic multicycle_i,
  input logic ex_ready_i,
  input logic ex_valid_i
);

  //////////////////////////////
  // Strobe rules
  //////////////////////////////

  // Writeback port idle in the first cycle out of reset
  we_idle_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !we_wb_i
  ) else $error("regfile_we_wb_o high in the cycle after reset release");

  // First high-half cycle stalls the stage unless a branch resolves
  multicycle_stalls: assert property (
    @(posedge clk) disable iff (!rst_n) (multicycle_i && !branch_in_ex_i) |-> !ex_ready_i
  ) else $error("ex_ready_o high during a multicycle product");

  // Valid only with writeback ready
  valid_needs_wb: assert property (
    @(posedge clk) disable iff (!rst_n) ex_valid_i |-> wb_ready_i
  ) else $error("ex_valid_o high while wb_ready_i low");

endmodule

// File: design/ex_stage.sv
// Execute stage top level
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // ALU operation from decode
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  input  logic              alu_en_i,
  // Multiplier operation from decode
  input  ex_pkg::mul_op_e   mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  input  ex_pkg::word_t     mult_operand_c_i,
  input  logic              mult_en_i,
  // CSR access
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              branch_in_ex_i,
  // Destination registers
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              regfile_we_i,
  // Load/store unit
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  // Forwarding port to decode
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  // Writeback port
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  // Branch resolution to fetch
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  word_t alu_result;
  logic  alu_cmp_result;
  word_t mult_result;
  logic  mult_ready;

  // Branch decision comes straight from the compare
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  //////////////////////////////
  // Units
  //////////////////////////////

  ex_alu alu0 (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult mult0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .op_c_i       (mult_operand_c_i),
    // Stage ready releases the high-half result
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_writeback wb0 (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .mult_ready_i           (mult_ready),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .lsu_en_i               (lsu_en_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// File: design/ex_writeback.sv
// Execute stage write ports and strobes
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              mult_ready_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              regfile_we_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              branch_in_ex_i,
  input  logic              wb_ready_i,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  reg_addr_t waddr_lsu_q;
  logic      we_lsu_q;
  logic      lsu_we_kept;
  logic      units_ready;

  //////////////////////////////
  // ALU write port
  //////////////////////////////

  // CSR data first then multiplier then ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = {`EX_XLEN{1'b0}};
    end
  end

  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  // A faulting access never writes
  assign lsu_we_kept = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q    <= 1'b0;
      waddr_lsu_q <= `EX_RADDR_RST;
    end else if (ex_valid_o) begin
      we_lsu_q <= lsu_we_kept;
      if (lsu_we_kept) begin
        waddr_lsu_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new so flush the stale write
      we_lsu_q <= 1'b0;
    end
  end

  assign regfile_waddr_wb_o = waddr_lsu_q;
  assign regfile_we_wb_o    = we_lsu_q;
  // Load data goes straight through
  assign regfile_wdata_wb_o = lsu_rdata_i;

  //////////////////////////////
  // Stage strobes
  //////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve here so they never wait on writeback
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

// File: design/ex_mult.sv
// Integer multiplier
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_mult (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            enable_i,
  input  ex_pkg::mul_op_e operator_i,
  input  ex_pkg::word_t   op_a_i,
  input  ex_pkg::word_t   op_b_i,
  input  ex_pkg::word_t   op_c_i,
  input  logic            ex_ready_i,
  output ex_pkg::word_t   result_o,
  output logic            multicycle_o,
  output logic            ready_o
);

  import ex_pkg::*;

  // High-half controller states
  typedef enum logic {
    ST_IDLE,
    ST_HIGH
  } mult_state_e;

  mult_state_e                  state_q;
  mult_state_e                  state_d;

  logic                         is_high;
  logic                         start_high;
  logic                         a_sign;
  logic                         b_sign;
  logic signed [2*`EX_XLEN-1:0] op_a_ext;
  logic signed [2*`EX_XLEN-1:0] op_b_ext;
  logic signed [2*`EX_XLEN-1:0] prod_full;
  logic [2*`EX_XLEN-1:0]        prod_q;
  word_t                        low_result;

  //////////////////////////////
  // Single cycle path
  //////////////////////////////

  // Low word of a * b, plus c for MAC
  always_comb begin
    if (operator_i == MUL_MAC) begin
      low_result = op_a_i * op_b_i + op_c_i;
    end else begin
      low_result = op_a_i * op_b_i;
    end
  end

  //////////////////////////////
  // High-half path
  //////////////////////////////

  assign is_high = (operator_i inside {MUL_MULH, MUL_MULHSU, MUL_MULHU});

  // Operand a signed for MULH and MULHSU
  assign a_sign = ((operator_i == MUL_MULH) || (operator_i == MUL_MULHSU))
                  & op_a_i[`EX_XLEN-1];
  // Operand b signed only for MULH
  assign b_sign = (operator_i == MUL_MULH) & op_b_i[`EX_XLEN-1];

  // Double width operands give the full product directly
  assign op_a_ext  = {{`EX_XLEN{a_sign}}, op_a_i};
  assign op_b_ext  = {{`EX_XLEN{b_sign}}, op_b_i};
  assign prod_full = op_a_ext * op_b_ext;

  // First cycle of a high-half op
  assign start_high = enable_i & is_high & (state_q == ST_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (start_high) state_d = ST_HIGH;
      // Leave once EX hands the op on
      ST_HIGH: if (ex_ready_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Full product held for the second cycle
  always_ff @(posedge clk) begin
    if (start_high) begin
      prod_q <= prod_full;
    end
  end

  // Outputs
  assign multicycle_o = start_high;
  assign ready_o      = ~start_high;
  assign result_o     = (state_q == ST_HIGH) ? prod_q[2*`EX_XLEN-1:`EX_XLEN] : low_result;

endmodule

// File: design/ex_alu.sv
// Integer ALU
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  import ex_pkg::*;

  // Shared adder and subtractor
  logic                    adder_sub;
  word_t                   adder_op_b;
  logic [`EX_XLEN:0]       adder_full;
  word_t                   adder_result;
  logic                    adder_carry;

  // Compare flags
  logic                    is_equal;
  logic                    is_less_s;
  logic                    is_less_u;

  // Barrel shifter
  logic                    shift_left;
  logic                    shift_fill;
  logic [`EX_SHAMT_W-1:0]  shift_amt;
  word_t                   shift_op;
  logic [`EX_XLEN:0]       shift_ext;
  word_t                   shift_right_res;
  word_t                   shift_result;

  // Mirror a word so that one right shifter also does left shifts
  function automatic word_t bit_reverse(input word_t value);
    word_t rev;
    for (int i = 0; i < `EX_XLEN; i++) begin
      rev[i] = value[`EX_XLEN-1-i];
    end
    return rev;
  endfunction

  //////////////////////////////
  // Adder
  //////////////////////////////

  // Everything except ADD subtracts
  assign adder_sub    = (operator_i != ALU_ADD);
  assign adder_op_b   = adder_sub ? ~operand_b_i : operand_b_i;
  assign adder_full   = {1'b0, operand_a_i} + {1'b0, adder_op_b}
                      + {{`EX_XLEN{1'b0}}, adder_sub};
  assign adder_result = adder_full[`EX_XLEN-1:0];
  assign adder_carry  = adder_full[`EX_XLEN];

  // Flags from a - b
  assign is_equal  = (adder_result == '0);
  // No borrow means a >= b unsigned
  assign is_less_u = ~adder_carry;
  // Differing signs decide directly, else sign of difference
  assign is_less_s = (operand_a_i[`EX_XLEN-1] ^ operand_b_i[`EX_XLEN-1]) ?
                     operand_a_i[`EX_XLEN-1] : adder_result[`EX_XLEN-1];

  //////////////////////////////
  // Shifter
  //////////////////////////////

  assign shift_left      = (operator_i == ALU_SLL);
  assign shift_amt       = operand_b_i[`EX_SHAMT_W-1:0];
  // Sign fill only for arithmetic right shift
  assign shift_fill      = (operator_i == ALU_SRA) & operand_a_i[`EX_XLEN-1];
  assign shift_op        = shift_left ? bit_reverse(operand_a_i) : operand_a_i;
  assign shift_ext       = $signed({shift_fill, shift_op}) >>> shift_amt;
  assign shift_right_res = shift_ext[`EX_XLEN-1:0];
  assign shift_result    = shift_left ? bit_reverse(shift_right_res) : shift_right_res;

  //////////////////////////////
  // Compare and result muxes
  //////////////////////////////

  // Branch condition or less-than bit
  always_comb begin
    cmp_result_o = 1'b0;
    case (operator_i)
      ALU_EQ:           cmp_result_o = is_equal;
      ALU_NE:           cmp_result_o = ~is_equal;
      ALU_LT, ALU_SLT:  cmp_result_o = is_less_s;
      ALU_GE:           cmp_result_o = ~is_less_s;
      ALU_LTU, ALU_SLTU: cmp_result_o = is_less_u;
      ALU_GEU:          cmp_result_o = ~is_less_u;
      default:          cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    result_o = '0;
    case (operator_i)
      ALU_ADD, ALU_SUB:          result_o = adder_result;
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      // Compares return the flag zero extended
      default:                   result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

// File: design/ex_pkg.sv
// Execute stage types
`include "ex_consts.svh"

package ex_pkg;

  // Operand and result word
  typedef logic [`EX_XLEN-1:0] word_t;

  // Register file address
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t;

  // ALU operations
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch conditions
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [`EX_MUL_OP_W-1:0] {
    MUL_MUL    = 3'd0,
    MUL_MAC    = 3'd1,
    MUL_MULH   = 3'd2,
    MUL_MULHSU = 3'd3,
    MUL_MULHU  = 3'd4
  } mul_op_e;

endpackage

// File: include/ex_consts.svh
// Execute stage constants
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Data word width
`define EX_XLEN      32
// Register file address width
`define EX_RADDR_W   6
// Shift amount width
`define EX_SHAMT_W   5

// Opcode widths
`define EX_ALU_OP_W  4
`define EX_MUL_OP_W  3

//////////////////////////////
// Reset values
//////////////////////////////

// EX/WB address after reset
`define EX_RADDR_RST 6'd0

`endif
